// File: verilog/mac_defs.svh
`ifndef MAC_DEFS_SVH
`define MAC_DEFS_SVH

// ---------------------------------------------------------------------------
// ring geometry
// ---------------------------------------------------------------------------
`define MAC_SLOT_COUNT     4
`define MAC_SLOT_BITS      2
`define MAC_SLOT_BYTES     64
`define MAC_MAX_PAYLOAD    60          // slot minus four crc bytes
`define MAC_ADDR_BITS      16

// ---------------------------------------------------------------------------
// ethernet framing
// ---------------------------------------------------------------------------
`define MAC_PREAMBLE_BYTE  8'h55
`define MAC_PREAMBLE_LEN   7
`define MAC_SFD_BYTE       8'hd5
`define MAC_IFG_CYCLES     12

// crc register after a good frame plus its fcs
`define MAC_CRC_RESIDUE    32'hc704_dd7b

`endif

// File: verilog/mac_pkg.sv
`default_nettype none

`include "mac_defs.svh"

package mac_pkg;

    typedef logic [7:0]                byte_t;
    typedef logic [`MAC_ADDR_BITS-1:0] pkt_addr_t;     // byte address or packet length
    typedef logic [`MAC_SLOT_BITS-1:0] slot_t;

    typedef enum logic [2:0] {
        op_read,
        op_read_len,
        op_read_next,
        op_write,
        op_write_len,
        op_write_next
    } host_op_e;

    typedef struct packed {
        host_op_e  op;
        pkt_addr_t addr;
        byte_t     value;
    } host_req_t;

    typedef struct packed {
        byte_t data;
        logic  en;
    } gmii_tx_t;

    typedef struct packed {
        byte_t data;
        logic  dv;
        logic  er;
    } gmii_rx_t;

    // crc-32 over one byte, poly 04c11db7, data[0] is the first bit on the wire
    function automatic logic [31:0] crc32_next(input byte_t data, input logic [31:0] crc);
        logic [31:0] c;
        logic        fb;
        c = crc;
        for (int i = 0; i < 8; i++)
        begin
            fb = c[31] ^ data[i];
            c  = {c[30:0], 1'b0} ^ (fb ? 32'h04c1_1db7 : 32'h0);
        end
        return c;
    endfunction

    // fcs byte idx of a crc register, complemented and bit reversed
    function automatic byte_t crc32_fcs_byte(input logic [31:0] crc, input logic [1:0] idx);
        byte_t b;
        byte_t r;
        b = crc[31 - 8 * idx -: 8];
        for (int i = 0; i < 8; i++)
            r[i] = ~b[7 - i];
        return r;
    endfunction

endpackage

`default_nettype wire

// File: verilog/packet_ring.sv
`timescale 1ns/1ns
`default_nettype none

`include "mac_defs.svh"

module packet_ring #(
    parameter int SLOTS = `MAC_SLOT_COUNT
) (
    input  wire                     clock,
    input  wire                     reset,
    input  wire                     wr_strobe,
    input  wire mac_pkg::pkt_addr_t wr_addr,
    input  wire mac_pkg::byte_t     wr_byte,
    input  wire                     commit,
    input  wire mac_pkg::pkt_addr_t commit_len,
    input  wire mac_pkg::pkt_addr_t rd_addr,
    output mac_pkg::byte_t          head_byte,
    output mac_pkg::pkt_addr_t      head_len,
    input  wire                     release_slot,
    output logic                    full,
    output logic                    empty
);

    localparam int OFF_BITS = $clog2(`MAC_SLOT_BYTES);
    localparam int CNT_BITS = $clog2(SLOTS + 1);

    mac_pkg::byte_t      mem [SLOTS * `MAC_SLOT_BYTES];
    mac_pkg::pkt_addr_t  len_mem [SLOTS];

    mac_pkg::slot_t      head_idx;              // oldest committed slot
    mac_pkg::slot_t      open_idx;              // slot being filled
    logic [CNT_BITS-1:0] count;                 // committed slots
    logic [CNT_BITS-1:0] count_next;

    function automatic mac_pkg::slot_t slot_inc(input mac_pkg::slot_t s);
        return (s == mac_pkg::slot_t'(SLOTS - 1)) ? '0 : s + 1'b1;
    endfunction

    always_comb
    begin
        count_next = count;
        if (commit && !release_slot)
            count_next = count + 1'b1;
        else if (release_slot && !commit)
            count_next = count - 1'b1;
    end

    // slot storage
    always_ff @(posedge clock)
    begin
        if (wr_strobe && wr_addr < `MAC_SLOT_BYTES)
            mem[{open_idx, wr_addr[OFF_BITS-1:0]}] <= wr_byte;
        if (commit)
            len_mem[open_idx] <= commit_len;
    end

    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            head_idx <= '0;
            open_idx <= '0;
            count    <= '0;
            full     <= 1'b0;
            empty    <= 1'b1;
        end
        else
        begin
            if (commit)
                open_idx <= slot_inc(open_idx);
            if (release_slot)
                head_idx <= slot_inc(head_idx);
            count <= count_next;
            full  <= (count_next == CNT_BITS'(SLOTS - 1));   // all but the open slot
            empty <= (count_next == '0);
        end
    end

    assign head_byte = mem[{head_idx, rd_addr[OFF_BITS-1:0]}];
    assign head_len  = len_mem[head_idx];

endmodule

`default_nettype wire

// File: verilog/host_command.sv
`timescale 1ns/1ns
`default_nettype none

`include "mac_defs.svh"

module host_command (
    input  wire                     clock,
    input  wire                     reset,
    input  wire                     host_start,
    input  wire mac_pkg::host_req_t host_req,
    output logic                    host_done,
    output mac_pkg::pkt_addr_t      host_result,
    // transmit ring, producer side
    output logic                    wr_strobe,
    output mac_pkg::pkt_addr_t      wr_addr,
    output mac_pkg::byte_t          wr_byte,
    output logic                    commit,
    output mac_pkg::pkt_addr_t      commit_len,
    input  wire                     full,
    // receive ring, consumer side
    output mac_pkg::pkt_addr_t      rd_addr,
    input  wire mac_pkg::byte_t     head_byte,
    input  wire mac_pkg::pkt_addr_t head_len,
    output logic                    release_slot,
    input  wire                     empty
);

    mac_pkg::pkt_addr_t tx_len;                 // highest written address plus one
    logic               in_range;

    assign in_range = host_req.addr < `MAC_MAX_PAYLOAD;

    // ring accesses happen in the start cycle
    assign wr_strobe    = host_start && host_req.op == mac_pkg::op_write && in_range;
    assign wr_addr      = host_req.addr;
    assign wr_byte      = host_req.value;
    assign commit       = host_start && host_req.op == mac_pkg::op_write_next && !full;
    assign commit_len   = tx_len;
    assign rd_addr      = host_req.addr;
    assign release_slot = host_start && host_req.op == mac_pkg::op_read_next && !empty;

    always_ff @(posedge clock)
    begin
        if (reset)
            tx_len <= '0;
        else if (commit)
            tx_len <= '0;                       // next slot starts empty
        else if (wr_strobe && host_req.addr >= tx_len)
            tx_len <= host_req.addr + 1'b1;
    end

    always_ff @(posedge clock)
    begin
        if (reset)
            host_done <= 1'b0;
        else
            host_done <= host_start;
    end

    always_ff @(posedge clock)
    begin
        if (host_start)
        begin
            case (host_req.op)
                mac_pkg::op_write:
                    host_result <= mac_pkg::pkt_addr_t'(!in_range);    // 1 when past payload
                mac_pkg::op_write_len:
                    host_result <= tx_len;
                mac_pkg::op_write_next:
                    host_result <= mac_pkg::pkt_addr_t'(full);         // 1 on overflow
                mac_pkg::op_read:
                    if (!empty && host_req.addr < head_len)
                        host_result <= mac_pkg::pkt_addr_t'(head_byte);
                    else
                        host_result <= '0;
                mac_pkg::op_read_len:
                    host_result <= empty ? '0 : head_len;
                mac_pkg::op_read_next:
                    host_result <= mac_pkg::pkt_addr_t'(empty);        // 1 when nothing left
                default:
                    host_result <= '0;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: verilog/gmii_tx_framer.sv
`timescale 1ns/1ns
`default_nettype none

`include "mac_defs.svh"

module gmii_tx_framer (
    input  wire                     clock,
    input  wire                     reset,
    output mac_pkg::gmii_tx_t       gmii_tx,
    output mac_pkg::pkt_addr_t      rd_addr,
    input  wire mac_pkg::byte_t     head_byte,
    input  wire mac_pkg::pkt_addr_t head_len,
    input  wire                     empty,
    output logic                    release_slot
);

    typedef enum logic [2:0] {
        st_idle,
        st_preamble,
        st_sfd,
        st_data,
        st_crc,
        st_gap
    } state_e;

    state_e             state;
    mac_pkg::pkt_addr_t cnt;                    // shared by preamble, data, fcs and gap
    logic [31:0]        crc;

    assign rd_addr = cnt;

    // slot goes back as en drops
    assign release_slot = (state == st_gap) && (cnt == '0);

    // crc runs over payload bytes only
    always_ff @(posedge clock)
    begin
        if (state == st_sfd)
            crc <= '1;
        else if (state == st_data)
            crc <= mac_pkg::crc32_next(head_byte, crc);
    end

    // ---------------------------------------------------------------------------
    // frame sequencer, gmii_tx is registered
    // ---------------------------------------------------------------------------
    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            state   <= st_idle;
            cnt     <= '0;
            gmii_tx <= '0;
        end
        else
        begin
            case (state)
                st_idle:
                begin
                    gmii_tx <= '0;
                    cnt     <= '0;
                    if (!empty)
                        state <= st_preamble;
                end
                st_preamble:
                begin
                    gmii_tx <= '{data: `MAC_PREAMBLE_BYTE, en: 1'b1};
                    cnt     <= cnt + 1'b1;
                    if (cnt == `MAC_PREAMBLE_LEN - 1)
                        state <= st_sfd;
                end
                st_sfd:
                begin
                    gmii_tx <= '{data: `MAC_SFD_BYTE, en: 1'b1};
                    cnt     <= '0;
                    state   <= (head_len == '0) ? st_crc : st_data;    // empty payload
                end
                st_data:
                begin
                    gmii_tx <= '{data: head_byte, en: 1'b1};
                    cnt     <= cnt + 1'b1;
                    if (cnt + 1'b1 == head_len)
                    begin
                        cnt   <= '0;
                        state <= st_crc;
                    end
                end
                st_crc:
                begin
                    gmii_tx <= '{data: mac_pkg::crc32_fcs_byte(crc, cnt[1:0]), en: 1'b1};
                    cnt     <= cnt + 1'b1;
                    if (cnt == 3)
                    begin
                        cnt   <= '0;
                        state <= st_gap;
                    end
                end
                st_gap:
                begin
                    gmii_tx <= '0;
                    cnt     <= cnt + 1'b1;
                    if (cnt == `MAC_IFG_CYCLES - 1)
                        state <= st_idle;
                end
                default:
                    state <= st_idle;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: verilog/gmii_rx_deframer.sv
`timescale 1ns/1ns
`default_nettype none

`include "mac_defs.svh"

module gmii_rx_deframer (
    input  wire                    clock,
    input  wire                    reset,
    input  wire mac_pkg::gmii_rx_t gmii_rx,
    output logic                   wr_strobe,
    output mac_pkg::pkt_addr_t     wr_addr,
    output mac_pkg::byte_t         wr_byte,
    output logic                   commit,
    output mac_pkg::pkt_addr_t     commit_len,
    input  wire                    full
);

    typedef enum logic [1:0] {
        st_hunt,                                // preamble and sfd search
        st_data,
        st_drop                                 // wait for dv to fall
    } state_e;

    state_e             state;
    logic [3:0]         pre_cnt;                // preamble bytes seen
    mac_pkg::pkt_addr_t count;                  // bytes after sfd, fcs included
    logic [31:0]        crc;
    logic               byte_ok;
    logic               frame_ok;

    assign byte_ok   = state == st_data && gmii_rx.dv && !gmii_rx.er
                       && count < `MAC_SLOT_BYTES;
    assign wr_strobe = byte_ok;
    assign wr_addr   = count;
    assign wr_byte   = gmii_rx.data;

    // commit in the first cycle with dv low
    assign frame_ok   = crc == `MAC_CRC_RESIDUE && count >= 4;
    assign commit     = state == st_data && !gmii_rx.dv && frame_ok && !full;
    assign commit_len = count - 3'd4;           // strip the fcs

    always_ff @(posedge clock)
    begin
        if (state == st_hunt)
            crc <= '1;
        else if (byte_ok)
            crc <= mac_pkg::crc32_next(gmii_rx.data, crc);
    end

    // ---------------------------------------------------------------------------
    // frame tracking
    // ---------------------------------------------------------------------------
    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            state   <= st_hunt;
            pre_cnt <= '0;
            count   <= '0;
        end
        else if (!gmii_rx.dv)
        begin
            state   <= st_hunt;                 // end of frame or idle line
            pre_cnt <= '0;
        end
        else if (gmii_rx.er)
            state <= st_drop;
        else
        begin
            case (state)
                st_hunt:
                    if (gmii_rx.data == `MAC_PREAMBLE_BYTE && pre_cnt < `MAC_PREAMBLE_LEN)
                        pre_cnt <= pre_cnt + 1'b1;
                    else if (gmii_rx.data == `MAC_SFD_BYTE && pre_cnt == `MAC_PREAMBLE_LEN)
                    begin
                        state <= st_data;
                        count <= '0;
                    end
                    else
                        state <= st_drop;      // short, long or broken preamble
                st_data:
                    if (count < `MAC_SLOT_BYTES)
                        count <= count + 1'b1;
                    else
                        state <= st_drop;      // oversize
                default:
                    state <= st_drop;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: verilog/mac_buffer_top.sv
`timescale 1ns/1ns
`default_nettype none

`include "mac_defs.svh"

module mac_buffer_top (
    input  wire                     clock,
    input  wire                     reset,
    input  wire                     host_start,
    input  wire mac_pkg::host_req_t host_req,
    output logic                    host_done,
    output mac_pkg::pkt_addr_t      host_result,
    output mac_pkg::gmii_tx_t       gmii_tx,
    input  wire mac_pkg::gmii_rx_t  gmii_rx
);

    // transmit ring, host writes and framer reads
    logic               tx_wr_strobe;
    mac_pkg::pkt_addr_t tx_wr_addr;
    mac_pkg::byte_t     tx_wr_byte;
    logic               tx_commit;
    mac_pkg::pkt_addr_t tx_commit_len;
    logic               tx_full;
    mac_pkg::pkt_addr_t tx_rd_addr;
    mac_pkg::byte_t     tx_head_byte;
    mac_pkg::pkt_addr_t tx_head_len;
    logic               tx_release;
    logic               tx_empty;

    // receive ring, deframer writes and host reads
    logic               rx_wr_strobe;
    mac_pkg::pkt_addr_t rx_wr_addr;
    mac_pkg::byte_t     rx_wr_byte;
    logic               rx_commit;
    mac_pkg::pkt_addr_t rx_commit_len;
    logic               rx_full;
    mac_pkg::pkt_addr_t rx_rd_addr;
    mac_pkg::byte_t     rx_head_byte;
    mac_pkg::pkt_addr_t rx_head_len;
    logic               rx_release;
    logic               rx_empty;

    packet_ring #(.SLOTS(`MAC_SLOT_COUNT)) tx_ring (
        .clock(clock), .reset(reset),
        .wr_strobe(tx_wr_strobe), .wr_addr(tx_wr_addr), .wr_byte(tx_wr_byte),
        .commit(tx_commit), .commit_len(tx_commit_len),
        .rd_addr(tx_rd_addr), .head_byte(tx_head_byte), .head_len(tx_head_len),
        .release_slot(tx_release), .full(tx_full), .empty(tx_empty)
    );

    packet_ring #(.SLOTS(`MAC_SLOT_COUNT)) rx_ring (
        .clock(clock), .reset(reset),
        .wr_strobe(rx_wr_strobe), .wr_addr(rx_wr_addr), .wr_byte(rx_wr_byte),
        .commit(rx_commit), .commit_len(rx_commit_len),
        .rd_addr(rx_rd_addr), .head_byte(rx_head_byte), .head_len(rx_head_len),
        .release_slot(rx_release), .full(rx_full), .empty(rx_empty)
    );

    host_command i_host_command (
        .clock(clock), .reset(reset),
        .host_start(host_start), .host_req(host_req),
        .host_done(host_done), .host_result(host_result),
        .wr_strobe(tx_wr_strobe), .wr_addr(tx_wr_addr), .wr_byte(tx_wr_byte),
        .commit(tx_commit), .commit_len(tx_commit_len), .full(tx_full),
        .rd_addr(rx_rd_addr), .head_byte(rx_head_byte), .head_len(rx_head_len),
        .release_slot(rx_release), .empty(rx_empty)
    );

    gmii_tx_framer i_tx_framer (
        .clock(clock), .reset(reset),
        .gmii_tx(gmii_tx),
        .rd_addr(tx_rd_addr), .head_byte(tx_head_byte), .head_len(tx_head_len),
        .empty(tx_empty), .release_slot(tx_release)
    );

    gmii_rx_deframer i_rx_deframer (
        .clock(clock), .reset(reset),
        .gmii_rx(gmii_rx),
        .wr_strobe(rx_wr_strobe), .wr_addr(rx_wr_addr), .wr_byte(rx_wr_byte),
        .commit(rx_commit), .commit_len(rx_commit_len), .full(rx_full)
    );

endmodule

`default_nettype wire

// File: tests/tb_vectors.svh
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

// columns: step kind, payload length (address for commands), corruption, command op, expected
// expected is the host_result for cmd rows, frames accepted for tx rows,
// and 1 for a kept rx frame or 0 for a dropped one
localparam int step_count = 21;

localparam step_t steps [step_count] = '{
    // ------------------------------------------------------------------------
    // both rings empty after reset
    // ------------------------------------------------------------------------
    '{step_cmd,      16'd0,  corrupt_none,      mac_pkg::op_read_next,  16'd1},
    '{step_cmd,      16'd0,  corrupt_none,      mac_pkg::op_read_len,   16'd0},
    '{step_cmd,      16'd0,  corrupt_none,      mac_pkg::op_write_len,  16'd0},
    '{step_cmd,      16'd60, corrupt_none,      mac_pkg::op_write,      16'd1},   // past payload
    '{step_cmd,      16'd0,  corrupt_none,      mac_pkg::op_read,       16'd0},
    // ------------------------------------------------------------------------
    // transmit path
    // ------------------------------------------------------------------------
    '{step_tx,       16'd20, corrupt_none,      mac_pkg::op_read,       16'd1},
    '{step_tx,       16'd1,  corrupt_none,      mac_pkg::op_read,       16'd1},
    '{step_tx,       16'd60, corrupt_none,      mac_pkg::op_read,       16'd1},
    '{step_tx_burst, 16'd9,  corrupt_none,      mac_pkg::op_read,       16'd3},   // 4th overflows
    // ------------------------------------------------------------------------
    // receive path
    // ------------------------------------------------------------------------
    '{step_rx,       16'd16, corrupt_none,      mac_pkg::op_read,       16'd1},
    '{step_rx,       16'd60, corrupt_none,      mac_pkg::op_read,       16'd1},
    '{step_rx,       16'd0,  corrupt_none,      mac_pkg::op_read,       16'd1},   // fcs only
    '{step_rx,       16'd1,  corrupt_none,      mac_pkg::op_read,       16'd1},
    '{step_rx,       16'd12, corrupt_crc,       mac_pkg::op_read,       16'd0},
    '{step_rx,       16'd12, corrupt_er,        mac_pkg::op_read,       16'd0},
    '{step_rx,       16'd12, corrupt_short_pre, mac_pkg::op_read,       16'd0},
    '{step_rx,       16'd12, corrupt_long_pre,  mac_pkg::op_read,       16'd0},
    '{step_rx,       16'd61, corrupt_none,      mac_pkg::op_read,       16'd0},   // oversize
    '{step_rx,       16'd24, corrupt_none,      mac_pkg::op_read,       16'd1},
    '{step_cmd,      16'd0,  corrupt_none,      mac_pkg::op_read_next,  16'd1},
    '{step_cmd,      16'd0,  corrupt_none,      mac_pkg::op_write_len,  16'd0}
};

`endif

// File: tests/tb_mac_buffer.sv
`timescale 1ns/1ns
`default_nettype none

`include "mac_defs.svh"

module tb_mac_buffer;

    typedef enum logic [1:0] {step_cmd, step_tx, step_tx_burst, step_rx} step_e;
    typedef enum logic [2:0] {
        corrupt_none,
        corrupt_crc,
        corrupt_er,
        corrupt_short_pre,
        corrupt_long_pre
    } corrupt_e;

    typedef struct packed {
        step_e              kind;
        mac_pkg::pkt_addr_t len;
        corrupt_e           corrupt;
        mac_pkg::host_op_e  op;
        mac_pkg::pkt_addr_t expected;
    } step_t;

    `include "tb_vectors.svh"

    localparam int clock_period = 40;
    localparam int start_limit  = 4 * `MAC_IFG_CYCLES;   // cycles to wait for en

    logic               clock;
    logic               reset;
    logic               host_start;
    mac_pkg::host_req_t host_req;
    logic               host_done;
    mac_pkg::pkt_addr_t host_result;
    mac_pkg::gmii_tx_t  gmii_tx;
    mac_pkg::gmii_rx_t  gmii_rx;

    logic [31:0]        lcg_state;
    mac_pkg::byte_t     payload [`MAC_SLOT_BYTES];

    mac_buffer_top i_dut (
        .clock(clock), .reset(reset),
        .host_start(host_start), .host_req(host_req),
        .host_done(host_done), .host_result(host_result),
        .gmii_tx(gmii_tx), .gmii_rx(gmii_rx)
    );

    always #(clock_period / 2) clock = ~clock;

    // ------------------------------------------------------------------------
    // failure reporting and compares
    // ------------------------------------------------------------------------
    task automatic fail_run(input string why);
        $display("%s", why);
        $display("RESULT: FAIL");
        $fatal(1, "run stopped at %0t ns", $time);
    endtask

    task automatic check_result(input string name, input mac_pkg::pkt_addr_t expected,
                                input mac_pkg::pkt_addr_t actual);
        if (actual !== expected)
            fail_run($sformatf("MISMATCH at %0t ns: %s expected %h got %h",
                               $time, name, expected, actual));
    endtask

    task automatic check_tx_byte(input string name, input mac_pkg::byte_t expected,
                                 input mac_pkg::byte_t actual);
        if (actual !== expected)
            fail_run($sformatf("MISMATCH at %0t ns: %s expected %h got %h",
                               $time, name, expected, actual));
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        if (actual !== expected)
            fail_run($sformatf("MISMATCH at %0t ns: %s expected %b got %b",
                               $time, name, expected, actual));
    endtask

    // ------------------------------------------------------------------------
    // models
    // ------------------------------------------------------------------------
    function automatic mac_pkg::byte_t random_byte();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state[23:16];
    endfunction

    // reflected crc-32 giving the fcs with byte 0 first on the wire
    function automatic logic [31:0] fcs_model(input int len);
        logic [31:0] crc;
        crc = 32'hffff_ffff;
        for (int i = 0; i < len; i++)
            for (int b = 0; b < 8; b++)
                crc = (crc >> 1) ^ ((crc[0] ^ payload[i][b]) ? 32'hedb8_8320 : 32'h0);
        return ~crc;
    endfunction

    function automatic mac_pkg::byte_t frame_byte(input int idx, input int len,
                                                  input logic [31:0] fcs);
        if (idx < `MAC_PREAMBLE_LEN)
            return `MAC_PREAMBLE_BYTE;
        if (idx == `MAC_PREAMBLE_LEN)
            return `MAC_SFD_BYTE;
        if (idx < 8 + len)
            return payload[idx - 8];
        if (idx < 12 + len)
            return fcs[8 * (idx - 8 - len) +: 8];
        return 8'h00;                                    // past the end so the length check fails
    endfunction

    function automatic int worst_cycles(input step_t s);
        int frame;
        frame = 8 + s.len + 4 + `MAC_IFG_CYCLES + 4;   // preamble, fcs, gap, start latency
        case (s.kind)
            step_cmd: return 2;
            step_rx:  return frame + s.len + 8;
            default:  return s.len + 8 + s.expected * frame;
        endcase
    endfunction

    // ------------------------------------------------------------------------
    // step drivers entered on a falling edge
    // ------------------------------------------------------------------------
    task automatic run_command(input mac_pkg::host_op_e op, input mac_pkg::pkt_addr_t addr,
                               input mac_pkg::byte_t value, input mac_pkg::pkt_addr_t expected);
        host_start = 1'b1;
        host_req   = '{op: op, addr: addr, value: value};
        @(negedge clock);
        check_bit("host_done", 1'b1, host_done);        // one cycle after start
        check_result($sformatf("host_result (%s)", op.name()), expected, host_result);
        host_start = 1'b0;
    endtask

    task automatic capture_frames(input int frames, input int len);
        int          waited;
        int          idx;
        int          flen;
        logic [31:0] fcs;
        for (int f = 0; f < frames; f++)
        begin
            flen   = (f == 0) ? len : 0;                // later commits carry no bytes
            fcs    = fcs_model(flen);
            waited = 0;
            while (!gmii_tx.en)
            begin
                if (waited == start_limit)
                    fail_run($sformatf("frame %0d never started on gmii_tx", f));
                waited++;
                @(negedge clock);
            end
            idx = 0;
            while (gmii_tx.en)
            begin
                check_tx_byte($sformatf("gmii_tx.data[%0d]", idx),
                              frame_byte(idx, flen, fcs), gmii_tx.data);
                idx++;
                @(negedge clock);
            end
            check_result("frame length", 12 + flen, idx);
            for (int g = 1; g < `MAC_IFG_CYCLES; g++)
            begin
                @(negedge clock);
                check_bit("gmii_tx.en", 1'b0, gmii_tx.en);    // inter-frame gap
            end
        end
    endtask

    task automatic transmit_packet(input step_t s);
        int commits;
        commits = (s.kind == step_tx_burst) ? 4 : 1;
        for (int i = 0; i < s.len; i++)
            payload[i] = random_byte();
        for (int i = 0; i < s.len; i++)
            run_command(mac_pkg::op_write, i, payload[i], 0);
        run_command(mac_pkg::op_write, `MAC_MAX_PAYLOAD, 8'hff, 1);
        run_command(mac_pkg::op_write_len, 0, 8'h00, s.len);
        fork
            for (int i = 0; i < commits; i++)
                run_command(mac_pkg::op_write_next, 0, 8'h00, (i < s.expected) ? 0 : 1);
            capture_frames(s.expected, s.len);
        join
    endtask

    task automatic receive_frame(input step_t s);
        mac_pkg::byte_t bytes [$];
        logic [31:0]    fcs;
        int             pre_len;
        int             er_idx;
        pre_len = `MAC_PREAMBLE_LEN;
        if (s.corrupt == corrupt_short_pre)
            pre_len = `MAC_PREAMBLE_LEN - 1;
        else if (s.corrupt == corrupt_long_pre)
            pre_len = `MAC_PREAMBLE_LEN + 1;
        for (int i = 0; i < s.len; i++)
            payload[i] = random_byte();
        fcs = fcs_model(s.len);
        if (s.corrupt == corrupt_crc)
            fcs = fcs ^ 32'h0000_0100;
        for (int i = 0; i < pre_len; i++)
            bytes.push_back(`MAC_PREAMBLE_BYTE);
        bytes.push_back(`MAC_SFD_BYTE);
        for (int i = 0; i < s.len; i++)
            bytes.push_back(payload[i]);
        for (int i = 0; i < 4; i++)
            bytes.push_back(fcs[8 * i +: 8]);
        er_idx = (s.corrupt == corrupt_er) ? pre_len + 1 + s.len / 2 : -1;
        foreach (bytes[i])
        begin
            gmii_rx = '{data: bytes[i], dv: 1'b1, er: (i == er_idx)};
            @(negedge clock);
        end
        gmii_rx = '0;
        repeat (`MAC_IFG_CYCLES) @(negedge clock);      // idle line between frames
        run_command(mac_pkg::op_read_len, 0, 8'h00, (s.expected != 0) ? s.len : 0);
        if (s.expected != 0)
        begin
            for (int a = 0; a < s.len; a++)
                run_command(mac_pkg::op_read, a, 8'h00, payload[a]);
            run_command(mac_pkg::op_read, s.len, 8'h00, 0);
            run_command(mac_pkg::op_read_next, 0, 8'h00, 0);
        end
        run_command(mac_pkg::op_read_next, 0, 8'h00, 1);
    endtask

    // ------------------------------------------------------------------------
    // watchdog and main sequence
    // ------------------------------------------------------------------------
    initial
    begin : watchdog
        longint limit_ns;
        limit_ns = 16 + 2 * `MAC_IFG_CYCLES;            // reset and idle checks
        foreach (steps[i])
            limit_ns += worst_cycles(steps[i]);
        limit_ns = 2 * limit_ns * clock_period;
        #(limit_ns);
        fail_run($sformatf("timeout: tests did not finish within %0d ns", limit_ns));
    end

    initial
    begin : main
        clock      = 1'b0;
        reset      = 1'b1;
        host_start = 1'b0;
        host_req   = '0;
        gmii_rx    = '0;
        lcg_state  = 32'h665b_201a;
        repeat (2) @(negedge clock);
        reset = 1'b0;
        for (int i = 0; i < `MAC_IFG_CYCLES; i++)
        begin
            @(negedge clock);
            check_bit("gmii_tx.en", 1'b0, gmii_tx.en);
            check_bit("host_done", 1'b0, host_done);
        end
        foreach (steps[i])
        begin
            case (steps[i].kind)
                step_cmd: run_command(steps[i].op, steps[i].len, 8'h00, steps[i].expected);
                step_rx:  receive_frame(steps[i]);
                default:  transmit_packet(steps[i]);
            endcase
        end
        @(negedge clock);
        check_bit("host_done", 1'b0, host_done);        // done is a single pulse
        $display("RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// File: mac_buffer.f
+incdir+verilog
+incdir+tests
verilog/mac_pkg.sv
verilog/packet_ring.sv
verilog/host_command.sv
verilog/gmii_tx_framer.sv
verilog/gmii_rx_deframer.sv
verilog/mac_buffer_top.sv
tests/tb_mac_buffer.sv
